// ==== logic/armCtrl_params.svh ====
`ifndef ARM_CTRL_PARAMS_SVH
`define ARM_CTRL_PARAMS_SVH

// Instruction word, also the width of the ALU result bus
`define INSTR_W 32

// Register file index, R0 to R15
`define REG_W 4

// Data-processing opcode field, bits 24 to 21
`define ALUOP_W 4

// NZCV
`define FLAG_W 4

// One write enable per byte lane
`define MASK_W 4

`endif

// ==== logic/armIsaPkg.sv ====
`include "armCtrl_params.svh"

package armIsaPkg;

  // Condition field in bits 31:28
  typedef enum logic [3:0] {
    EQ = 4'b0000,  // Z set
    NE = 4'b0001,  // Z clear
    CS = 4'b0010,  // Unsigned higher or same
    CC = 4'b0011,
    MI = 4'b0100,  // Negative
    PL = 4'b0101,
    VS = 4'b0110,  // Overflow
    VC = 4'b0111,
    HI = 4'b1000,  // Unsigned higher
    LS = 4'b1001,
    GE = 4'b1010,  // Signed compares
    LT = 4'b1011,
    GT = 4'b1100,
    LE = 4'b1101,
    AL = 4'b1110   // 1111 is handled as always too
  } condCode_t;

  // Data-processing opcodes, in ARM encoding order
  typedef enum logic [`ALUOP_W-1:0] {
    OP_AND = 4'h0,
    OP_EOR, OP_SUB, OP_RSB, OP_ADD,   // SUB and ADD double as address math
    OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,   // Flags only, no register write
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } aluOp_t;

  // Coarse class from bits 27:26
  typedef enum logic [1:0] {
    DATAPROC  = 2'b00,
    LOADSTORE = 2'b01,
    BRANCH    = 2'b10,  // Also LDM/STM space
    OTHER     = 2'b11   // Coprocessor and SWI
  } instrClass_t;

endpackage

// ==== logic/ctrlTypesPkg.sv ====
`include "armCtrl_params.svh"

package ctrlTypesPkg;

  // Condition flags, same order as CPSR[31:28]
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // Register file read port select
  typedef struct packed {
    logic readRd;  // Store data comes from Rd
    logic readPc;  // Branch base is the PC
  } regSrc_t;

  // Immediate extender format
  typedef enum logic [1:0] {
    IMM8ROT = 2'b00,  // Rotated 8-bit data-processing immediate
    IMM12   = 2'b01,  // Load/store offset
    IMM24   = 2'b10   // Branch displacement
  } immSrc_t;

  // Controls leaving decode
  typedef struct packed {
    logic              aluSrc;      // Operand B is the immediate
    logic              memtoReg;
    logic              regWrite;
    logic              memWrite;
    logic              branch;
    logic              flagWrite;   // S bit of a data-processing op
    logic              pcSrc;       // Writes the PC
    logic              byteAccess;  // LDRB/STRB
    armIsaPkg::aluOp_t aluControl;
  } decodeCtrl_t;

  // Controls leaving execute, already condition gated
  typedef struct packed {
    logic               memWrite;
    logic               memtoReg;
    logic               regWrite;
    logic               pcSrc;
    logic               loadByte;
    logic [1:0]         byteOffset;  // Lane of a byte load
    logic [`MASK_W-1:0] byteMask;
  } memCtrl_t;

endpackage

// ==== logic/stageIfs.sv ====
`timescale 1ns/1ps

// Decode stage to execute stage
interface decodeIf;

  ctrlTypesPkg::decodeCtrl_t ctrl;
  armIsaPkg::condCode_t      cond;
  logic                      setFlags;
  logic                      pcSrc;     // Also tapped at the top for the PC-write pending

  modport src (
    output ctrl,
    output cond,
    output setFlags,
    output pcSrc
  );

  modport dst (
    input  ctrl,
    input  cond,
    input  setFlags,
    input  pcSrc
  );

endinterface

// Execute stage to memory stage, with flag forwarding coming back
interface execIf;

  ctrlTypesPkg::memCtrl_t ctrl;
  ctrlTypesPkg::flags_t   flagsNext;
  logic                   setFlags;
  logic                   valid;      // Occupied and condition passed
  ctrlTypesPkg::flags_t   fwdM;       // Flags in the memory stage
  logic                   fwdSetM;
  ctrlTypesPkg::flags_t   fwdW;       // Flags in the writeback stage
  logic                   fwdSetW;
  ctrlTypesPkg::flags_t   flagReg;    // Architectural NZCV

  modport src (
    output ctrl, flagsNext, setFlags, valid,
    input  fwdM, fwdSetM, fwdW, fwdSetW, flagReg
  );

  modport dst (
    input  ctrl, flagsNext, setFlags, valid,
    output fwdM, fwdSetM, fwdW, fwdSetW, flagReg
  );

endinterface

// ==== logic/condCheck.sv ====
`timescale 1ns/1ps

module condCheck (
  input  armIsaPkg::condCode_t cond,
  input  ctrlTypesPkg::flags_t flags,      // Forwarded NZCV
  input  ctrlTypesPkg::flags_t aluFlags,   // Fresh from the ALU
  input  logic                 flagWrite,
  output logic                 condEx,
  output ctrlTypesPkg::flags_t flagsNext
);

  logic signedGe;

  // N equals V means signed greater or equal
  assign signedGe = (flags.n == flags.v);

  always_comb begin
    case (cond)
      armIsaPkg::EQ: condEx = flags.z;
      armIsaPkg::NE: condEx = !flags.z;
      armIsaPkg::CS: condEx = flags.c;
      armIsaPkg::CC: condEx = !flags.c;
      armIsaPkg::MI: condEx = flags.n;
      armIsaPkg::PL: condEx = !flags.n;
      armIsaPkg::VS: condEx = flags.v;
      armIsaPkg::VC: condEx = !flags.v;
      armIsaPkg::HI: condEx = flags.c && !flags.z;
      armIsaPkg::LS: condEx = !flags.c || flags.z;
      armIsaPkg::GE: condEx = signedGe;
      armIsaPkg::LT: condEx = !signedGe;
      armIsaPkg::GT: condEx = !flags.z && signedGe;
      armIsaPkg::LE: condEx = flags.z || !signedGe;
      default:       condEx = 1'b1;         // AL and the 1111 code
    endcase
  end

  // Take ALU flags only for an S instruction that actually executes
  assign flagsNext = (flagWrite && condEx) ? aluFlags : flags;

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module instrDecoder (
  input  logic [`INSTR_W-1:0]   instrD,
  output ctrlTypesPkg::regSrc_t regSrcD,
  output ctrlTypesPkg::immSrc_t immSrcD,
  decodeIf.src                  dec
);

  armIsaPkg::instrClass_t    instrClass;
  armIsaPkg::aluOp_t         dpOp;
  ctrlTypesPkg::decodeCtrl_t ctrlD;
  logic                      immForm;    // I bit
  logic                      sBit;       // S bit, or L bit for load/store
  logic                      rdIsPc;
  logic                      isCompare;

  // ==============================
  // Instruction fields
  // ==============================

  assign instrClass = armIsaPkg::instrClass_t'(instrD[27:26]);
  assign dpOp       = armIsaPkg::aluOp_t'(instrD[24:21]);
  assign immForm    = instrD[25];
  assign sBit       = instrD[20];
  assign rdIsPc     = (instrD[15:12] == {`REG_W{1'b1}});
  assign isCompare  = (instrD[24:23] == 2'b10);  // TST TEQ CMP CMN

  // ==============================
  // Control decode
  // ==============================

  always_comb begin
    ctrlD   = '0;                      // Anything unsupported stays inactive
    regSrcD = '0;
    immSrcD = ctrlTypesPkg::IMM8ROT;
    case (instrClass)
      armIsaPkg::DATAPROC: begin
        // Register form needs an immediate shift, bit 4 set is RSR/mult/halfword
        if (immForm || !instrD[4]) begin
          // Compare opcodes without S are the misc space
          if (!isCompare || sBit) begin
            ctrlD.aluSrc     = immForm;
            ctrlD.regWrite   = !isCompare;  // Compares only touch flags
            ctrlD.flagWrite  = sBit;
            ctrlD.aluControl = dpOp;
          end
        end
      end

      armIsaPkg::LOADSTORE: begin
        // Register offset with bit 4 set is undefined
        if (!(immForm && instrD[4])) begin
          ctrlD.aluSrc     = !immForm;      // I bit is inverted here, 0 means 12-bit offset
          ctrlD.memtoReg   = sBit;
          ctrlD.regWrite   = sBit;          // LDR
          ctrlD.memWrite   = !sBit;         // STR
          ctrlD.byteAccess = instrD[22];
          // U bit picks the offset direction
          ctrlD.aluControl = instrD[23] ? armIsaPkg::OP_ADD : armIsaPkg::OP_SUB;
          regSrcD.readRd   = !sBit;         // Store data read from Rd
          immSrcD          = ctrlTypesPkg::IMM12;
        end
      end

      armIsaPkg::BRANCH: begin
        // Plain B only, LDM/STM and BL fall through inactive
        if (immForm && !instrD[24]) begin
          ctrlD.aluSrc     = 1'b1;
          ctrlD.branch     = 1'b1;
          ctrlD.aluControl = armIsaPkg::OP_ADD;  // PC + displacement
          regSrcD.readPc   = 1'b1;
          immSrcD          = ctrlTypesPkg::IMM24;
        end
      end

      default: begin
        // Coprocessor and SWI space
      end
    endcase

    // Any write to R15 redirects fetch
    ctrlD.pcSrc = ctrlD.branch | (ctrlD.regWrite & rdIsPc);
  end

  // ==============================
  // Bundle to execute
  // ==============================

  assign dec.ctrl     = ctrlD;
  assign dec.cond     = armIsaPkg::condCode_t'(instrD[31:28]);
  assign dec.setFlags = ctrlD.flagWrite;
  assign dec.pcSrc    = ctrlD.pcSrc;  // Decode-stage term of pcWrPendingF

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module executeStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 stallE,
  input  logic                 flushE,
  input  ctrlTypesPkg::flags_t aluFlagsE,
  input  logic [`INSTR_W-1:0]  aluResultE,   // Load/store address
  decodeIf.dst                 dec,
  output logic                 aluSrcE,
  output armIsaPkg::aluOp_t    aluControlE,
  output logic                 branchTakenE,
  output ctrlTypesPkg::flags_t flagsE,
  output logic                 pcSrcE,
  execIf.src                   exe
);

  ctrlTypesPkg::decodeCtrl_t ctrlE;
  armIsaPkg::condCode_t      condE;
  ctrlTypesPkg::flags_t      flagsNextE;
  logic                      setFlagsE;
  logic                      validE;       // Holds a real instruction
  logic                      condEx;
  logic [`MASK_W-1:0]        byteMaskE;

  // ==============================
  // Decode to execute register
  // ==============================

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE     <= '0;
      condE     <= armIsaPkg::EQ;    // All-zero encoding
      setFlagsE <= 1'b0;
      validE    <= 1'b0;
    end else if (flushE) begin       // Bubble
      ctrlE     <= '0;
      condE     <= armIsaPkg::EQ;
      setFlagsE <= 1'b0;
      validE    <= 1'b0;
    end else if (!stallE) begin
      ctrlE     <= dec.ctrl;
      condE     <= dec.cond;
      setFlagsE <= dec.setFlags;
      validE    <= 1'b1;
    end
  end

  // Newest flags win, memory then writeback then the flag register
  assign flagsE = exe.fwdSetM ? exe.fwdM :
                  exe.fwdSetW ? exe.fwdW : exe.flagReg;

  condCheck condCheck_i (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (ctrlE.flagWrite),
    .condEx    (condEx),
    .flagsNext (flagsNextE)
  );

  // Word access enables every lane, byte access one lane from the address
  assign byteMaskE = ctrlE.byteAccess ? (`MASK_W'(1) << aluResultE[1:0]) : '1;

  // ==============================
  // Gated controls to memory
  // ==============================

  always_comb begin
    exe.ctrl.memWrite   = ctrlE.memWrite & condEx;
    exe.ctrl.memtoReg   = ctrlE.memtoReg & condEx;
    exe.ctrl.regWrite   = ctrlE.regWrite & condEx;
    exe.ctrl.pcSrc      = ctrlE.pcSrc & condEx;
    exe.ctrl.loadByte   = ctrlE.byteAccess & ctrlE.memtoReg & condEx;
    exe.ctrl.byteOffset = aluResultE[1:0];
    exe.ctrl.byteMask   = byteMaskE;
  end

  assign exe.flagsNext = flagsNextE;
  assign exe.setFlags  = setFlagsE;
  assign exe.valid     = validE & condEx;  // Memory stage qualifies setFlags with this

  assign aluSrcE      = ctrlE.aluSrc;
  assign aluControlE  = ctrlE.aluControl;
  assign branchTakenE = ctrlE.branch & condEx;
  assign pcSrcE       = ctrlE.pcSrc;       // Ungated, pending check stays conservative

endmodule

// ==== logic/memWbStage.sv ====
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module memWbStage (
  input  logic               clk,
  input  logic               rstN,
  input  logic               stallM,
  input  logic               stallW,
  input  logic               flushW,
  execIf.dst                 exe,
  output logic               memWriteM,
  output logic               memtoRegM,
  output logic [`MASK_W-1:0] byteMaskM,
  output logic               pcSrcM,
  output logic               regWriteW,
  output logic               memtoRegW,
  output logic               pcSrcW,
  output logic [1:0]         byteOffsetW,
  output logic               loadByteW
);

  ctrlTypesPkg::memCtrl_t ctrlM;
  ctrlTypesPkg::flags_t   flagsM;
  ctrlTypesPkg::flags_t   flagsW;
  ctrlTypesPkg::flags_t   flagReg;
  logic                   setFlagsM;
  logic                   setFlagsW;

  // ==============================
  // Execute to memory register
  // ==============================

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlM     <= '0;
      flagsM    <= '0;
      setFlagsM <= 1'b0;
    end else if (!stallM) begin
      ctrlM     <= exe.ctrl;
      flagsM    <= exe.flagsNext;
      setFlagsM <= exe.setFlags & exe.valid;  // Failed condition sets nothing
    end
  end

  assign memWriteM = ctrlM.memWrite;
  assign memtoRegM = ctrlM.memtoReg;
  assign byteMaskM = ctrlM.byteMask;
  assign pcSrcM    = ctrlM.pcSrc;

  // ==============================
  // Memory to writeback register
  // ==============================

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {regWriteW, memtoRegW, pcSrcW, loadByteW} <= '0;
      byteOffsetW <= '0;
      flagsW      <= '0;
      setFlagsW   <= 1'b0;
    end else if (flushW) begin
      {regWriteW, memtoRegW, pcSrcW, loadByteW} <= '0;
      byteOffsetW <= '0;
      flagsW      <= '0;
      setFlagsW   <= 1'b0;
    end else if (!stallW) begin
      regWriteW   <= ctrlM.regWrite;
      memtoRegW   <= ctrlM.memtoReg;
      pcSrcW      <= ctrlM.pcSrc;
      loadByteW   <= ctrlM.loadByte;
      byteOffsetW <= ctrlM.byteOffset;  // Lane select for the load aligner
      flagsW      <= flagsM;
      setFlagsW   <= setFlagsM;
    end
  end

  // NZCV register, written as the instruction retires
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      flagReg <= '0;
    else if (setFlagsW && !stallW)
      flagReg <= flagsW;
  end

  // Forwarding back to execute
  assign exe.fwdM    = flagsM;
  assign exe.fwdSetM = setFlagsM;
  assign exe.fwdW    = flagsW;
  assign exe.fwdSetW = setFlagsW;
  assign exe.flagReg = flagReg;

endmodule

// ==== logic/armController.sv ====
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module armController (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [`INSTR_W-1:0]   instrD,
  input  ctrlTypesPkg::flags_t  aluFlagsE,
  input  logic [`INSTR_W-1:0]   aluResultE,
  input  logic                  stallE,
  input  logic                  flushE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushW,
  output ctrlTypesPkg::regSrc_t regSrcD,
  output ctrlTypesPkg::immSrc_t immSrcD,
  output logic                  aluSrcE,
  output armIsaPkg::aluOp_t     aluControlE,
  output logic                  branchTakenE,
  output ctrlTypesPkg::flags_t  flagsE,
  output logic                  memWriteM,
  output logic                  memtoRegM,
  output logic [`MASK_W-1:0]    byteMaskM,
  output logic                  regWriteW,
  output logic                  memtoRegW,
  output logic                  pcSrcW,
  output logic [1:0]            byteOffsetW,
  output logic                  loadByteW,
  output logic                  pcWrPendingF
);

  logic pcSrcE;
  logic pcSrcM;

  decodeIf decIf ();
  execIf   exeIf ();

  instrDecoder instrDecoder_i (
    .instrD  (instrD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .dec     (decIf.src)
  );

  executeStage executeStage_i (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .aluFlagsE    (aluFlagsE),
    .aluResultE   (aluResultE),
    .dec          (decIf.dst),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .flagsE       (flagsE),
    .pcSrcE       (pcSrcE),
    .exe          (exeIf.src)
  );

  memWbStage memWbStage_i (
    .clk         (clk),
    .rstN        (rstN),
    .stallM      (stallM),
    .stallW      (stallW),
    .flushW      (flushW),
    .exe         (exeIf.dst),
    .memWriteM   (memWriteM),
    .memtoRegM   (memtoRegM),
    .byteMaskM   (byteMaskM),
    .pcSrcM      (pcSrcM),
    .regWriteW   (regWriteW),
    .memtoRegW   (memtoRegW),
    .pcSrcW      (pcSrcW),
    .byteOffsetW (byteOffsetW),
    .loadByteW   (loadByteW)
  );

  // PC write somewhere between decode and memory, fetch must wait
  assign pcWrPendingF = decIf.pcSrc | pcSrcE | pcSrcM;

endmodule

// ==== test/tbArmController.sv ====
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module tbArmController;

  // One row of the stimulus table
  typedef struct packed {
    logic [`INSTR_W-1:0]   instr;
    ctrlTypesPkg::flags_t  aluFlags;   // Driven while the row sits in execute
    logic [`INSTR_W-1:0]   aluResult;
    logic                  flush;      // flushE alongside the row in decode
    ctrlTypesPkg::regSrc_t regSrc;
    ctrlTypesPkg::immSrc_t immSrc;
    logic                  aluSrc;
    armIsaPkg::aluOp_t     aluOp;
    logic                  branch;     // branchTakenE
    ctrlTypesPkg::flags_t  flags;      // flagsE seen by the row
    logic                  pend;       // pcWrPendingF while in decode and execute
    logic [1:0]            mem;        // memWriteM, memtoRegM
    logic [`MASK_W-1:0]    mask;
    logic [3:0]            wb;         // regWriteW, memtoRegW, pcSrcW, loadByteW
  } entry_t;

  logic                  clk;
  logic                  rstN;
  logic [`INSTR_W-1:0]   instrD;
  ctrlTypesPkg::flags_t  aluFlagsE;
  logic [`INSTR_W-1:0]   aluResultE;
  logic                  stallE;
  logic                  flushE;
  logic                  stallM;
  logic                  stallW;
  logic                  flushW;
  ctrlTypesPkg::regSrc_t regSrcD;
  ctrlTypesPkg::immSrc_t immSrcD;
  logic                  aluSrcE;
  armIsaPkg::aluOp_t     aluControlE;
  logic                  branchTakenE;
  ctrlTypesPkg::flags_t  flagsE;
  logic                  memWriteM;
  logic                  memtoRegM;
  logic [`MASK_W-1:0]    byteMaskM;
  logic                  regWriteW;
  logic                  memtoRegW;
  logic                  pcSrcW;
  logic [1:0]            byteOffsetW;
  logic                  loadByteW;
  logic                  pcWrPendingF;

  entry_t tbl[$];
  string  names[$];
  int     checks;
  int     errors;
  int     timeouts;

  armController armController_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  initial begin
    rstN = 1'b0;
    repeat (16) @(negedge clk);
    rstN = 1'b1;             // Released on a falling edge
  end

  // ==============================
  // Compare tasks
  // ==============================

  task automatic checkBit(input string test, input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s %s expected %b actual %b", test, what, exp, act);
    end
  endtask

  task automatic checkFlags(input string test, input ctrlTypesPkg::flags_t exp,
                            input ctrlTypesPkg::flags_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s flagsE expected %b actual %b", test, exp, act);  // NZCV order
    end
  endtask

  task automatic checkAluOp(input string test, input armIsaPkg::aluOp_t exp,
                            input armIsaPkg::aluOp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s aluControlE expected %s actual %s", test, exp.name(), act.name());
    end
  endtask

  task automatic checkImmSrc(input string test, input ctrlTypesPkg::immSrc_t exp,
                             input ctrlTypesPkg::immSrc_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s immSrcD expected %s actual %s", test, exp.name(), act.name());
    end
  endtask

  task automatic checkMask(input string test, input logic [`MASK_W-1:0] exp,
                           input logic [`MASK_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s byteMaskM expected %b actual %b", test, exp, act);
    end
  endtask

  task automatic checkOffset(input string test, input logic [1:0] exp,
                             input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s byteOffsetW expected %0d actual %0d", test, exp, act);
    end
  endtask

  // ==============================
  // Stimulus table
  // ==============================

  // Lane enable of a byte store, one bit per address low pair
  function automatic logic [`MASK_W-1:0] laneMask(input logic [`INSTR_W-1:0] addr);
    case (addr[1:0])
      2'd0:    laneMask = 4'b0001;
      2'd1:    laneMask = 4'b0010;
      2'd2:    laneMask = 4'b0100;
      default: laneMask = 4'b1000;
    endcase
  endfunction

  task automatic addEntry(
    input string name, input logic [31:0] instr, input logic [3:0] aluFlags,
    input logic [31:0] aluResult, input logic flush, input logic [1:0] regSrc,
    input ctrlTypesPkg::immSrc_t immSrc, input logic aluSrc, input armIsaPkg::aluOp_t aluOp,
    input logic branch, input logic [3:0] flags, input logic pend, input logic [1:0] mem,
    input logic [3:0] mask, input logic [3:0] wb);
    entry_t e;
    e.instr     = instr;
    e.aluFlags  = aluFlags;
    e.aluResult = aluResult;
    e.flush     = flush;
    e.regSrc    = regSrc;
    e.immSrc    = immSrc;
    e.aluSrc    = aluSrc;
    e.aluOp     = aluOp;
    e.branch    = branch;
    e.flags     = flags;
    e.pend      = pend;
    e.mem       = mem;
    e.mask      = mask;
    e.wb        = wb;
    tbl.push_back(e);
    names.push_back(name);
  endtask

  task automatic buildTable();
    logic [`INSTR_W-1:0] addrA;
    logic [`INSTR_W-1:0] addrB;
    addrA = $urandom(62);              // First draw also seeds the generator
    addrB = $urandom;
    // Decode forms
    addEntry("addImm", 32'hE2821005, 4'b0000, 32'h0, 1'b0,
             2'b00, ctrlTypesPkg::IMM8ROT, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b0000, 1'b0,
             2'b00, 4'b1111, 4'b1000);
    addEntry("subReg", 32'hE0443005, 4'b0000, 32'h0, 1'b0,
             2'b00, ctrlTypesPkg::IMM8ROT, 1'b0, armIsaPkg::OP_SUB, 1'b0, 4'b0000, 1'b0,
             2'b00, 4'b1111, 4'b1000);
    addEntry("ldrAdd", 32'hE5910004, 4'b0000, 32'h104, 1'b0,
             2'b00, ctrlTypesPkg::IMM12, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b0000, 1'b0,
             2'b01, 4'b1111, 4'b1100);
    addEntry("strSub", 32'hE5032008, 4'b0000, 32'hFF8, 1'b0,
             2'b10, ctrlTypesPkg::IMM12, 1'b1, armIsaPkg::OP_SUB, 1'b0, 4'b0000, 1'b0,
             2'b10, 4'b1111, 4'b0000);           // Word store, all lanes
    addEntry("branchAl", 32'hEA000010, 4'b0000, 32'h0, 1'b0,
             2'b01, ctrlTypesPkg::IMM24, 1'b1, armIsaPkg::OP_ADD, 1'b1, 4'b0000, 1'b1,
             2'b00, 4'b1111, 4'b0010);
    // CMP sets Z and C, then branches read them from M, W and the flag register
    addEntry("cmpFlags", 32'hE1510002, 4'b0110, 32'h0, 1'b0,
             2'b00, ctrlTypesPkg::IMM8ROT, 1'b0, armIsaPkg::OP_CMP, 1'b0, 4'b0000, 1'b1,
             2'b00, 4'b1111, 4'b0000);
    addEntry("beqTaken", 32'h0A000004, 4'b0000, 32'h0, 1'b0,
             2'b01, ctrlTypesPkg::IMM24, 1'b1, armIsaPkg::OP_ADD, 1'b1, 4'b0110, 1'b1,
             2'b00, 4'b1111, 4'b0010);
    addEntry("bneNot", 32'h1A000004, 4'b0000, 32'h0, 1'b0,
             2'b01, ctrlTypesPkg::IMM24, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b0110, 1'b1,
             2'b00, 4'b1111, 4'b0000);
    addEntry("bhiNot", 32'h8A000004, 4'b0000, 32'h0, 1'b0,
             2'b01, ctrlTypesPkg::IMM24, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b0110, 1'b1,
             2'b00, 4'b1111, 4'b0000);           // C set but Z set too
    addEntry("cmpNeg", 32'hE1510002, 4'b1000, 32'h0, 1'b0,
             2'b00, ctrlTypesPkg::IMM8ROT, 1'b0, armIsaPkg::OP_CMP, 1'b0, 4'b0110, 1'b0,
             2'b00, 4'b1111, 4'b0000);
    addEntry("bltTaken", 32'hBA000004, 4'b0000, 32'h0, 1'b0,
             2'b01, ctrlTypesPkg::IMM24, 1'b1, armIsaPkg::OP_ADD, 1'b1, 4'b1000, 1'b1,
             2'b00, 4'b1111, 4'b0010);           // N differs from V
    addEntry("bgeNot", 32'hAA000004, 4'b0000, 32'h0, 1'b0,
             2'b01, ctrlTypesPkg::IMM24, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b1000, 1'b1,
             2'b00, 4'b1111, 4'b0000);
    // Byte stores at random lanes
    addEntry("strbRandA", 32'hE5C32001, 4'b0000, addrA, 1'b0,
             2'b10, ctrlTypesPkg::IMM12, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b1000, 1'b0,
             2'b10, laneMask(addrA), 4'b0000);
    addEntry("strbRandB", 32'hE5C32002, 4'b0000, addrB, 1'b0,
             2'b10, ctrlTypesPkg::IMM12, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b1000, 1'b0,
             2'b10, laneMask(addrB), 4'b0000);
    addEntry("ldrb", 32'hE5D10003, 4'b0000, 32'h203, 1'b0,
             2'b00, ctrlTypesPkg::IMM12, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b1000, 1'b0,
             2'b01, 4'b1111, 4'b1101);
    addEntry("movPc", 32'hE1A0F000, 4'b0000, 32'h0, 1'b0,
             2'b00, ctrlTypesPkg::IMM8ROT, 1'b0, armIsaPkg::OP_MOV, 1'b0, 4'b1000, 1'b1,
             2'b00, 4'b1111, 4'b1010);
    // Flushed rows leave a bubble, the CMP must not touch the flags
    addEntry("flushStr", 32'hE5032008, 4'b0000, 32'h0, 1'b1,
             2'b10, ctrlTypesPkg::IMM12, 1'b0, armIsaPkg::OP_AND, 1'b0, 4'b1000, 1'b1,
             2'b00, 4'b1111, 4'b0000);
    addEntry("flushCmp", 32'hE1510002, 4'b0001, 32'h0, 1'b1,
             2'b00, ctrlTypesPkg::IMM8ROT, 1'b0, armIsaPkg::OP_AND, 1'b0, 4'b1000, 1'b0,
             2'b00, 4'b1111, 4'b0000);
    addEntry("addAfter", 32'hE2821005, 4'b0000, 32'h0, 1'b0,
             2'b00, ctrlTypesPkg::IMM8ROT, 1'b1, armIsaPkg::OP_ADD, 1'b0, 4'b1000, 1'b0,
             2'b00, 4'b1111, 4'b1000);
    addEntry("bvcTaken", 32'h7A000004, 4'b0000, 32'h0, 1'b0,
             2'b01, ctrlTypesPkg::IMM24, 1'b1, armIsaPkg::OP_ADD, 1'b1, 4'b1000, 1'b1,
             2'b00, 4'b1111, 4'b0010);
  endtask

  // ==============================
  // Stage checks and run
  // ==============================

  task automatic checkResetValues();
    checkBit("reset", "branchTakenE", 1'b0, branchTakenE);
    checkBit("reset", "memWriteM", 1'b0, memWriteM);
    checkBit("reset", "regWriteW", 1'b0, regWriteW);
    checkBit("reset", "pcSrcW", 1'b0, pcSrcW);
    checkBit("reset", "pcWrPendingF", 1'b0, pcWrPendingF);
    checkFlags("reset", 4'b0000, flagsE);
  endtask

  // Decode outputs still show the row, execute has just latched it
  task automatic checkExecute(input int i);
    checkBit(names[i], "regSrcD.readRd", tbl[i].regSrc.readRd, regSrcD.readRd);
    checkBit(names[i], "regSrcD.readPc", tbl[i].regSrc.readPc, regSrcD.readPc);
    checkImmSrc(names[i], tbl[i].immSrc, immSrcD);
    checkBit(names[i], "aluSrcE", tbl[i].aluSrc, aluSrcE);
    checkAluOp(names[i], tbl[i].aluOp, aluControlE);
    checkBit(names[i], "branchTakenE", tbl[i].branch, branchTakenE);
    checkFlags(names[i], tbl[i].flags, flagsE);
    checkBit(names[i], "pcWrPendingF", tbl[i].pend, pcWrPendingF);
  endtask

  task automatic checkMemory(input int i);
    checkBit(names[i], "memWriteM", tbl[i].mem[1], memWriteM);
    checkBit(names[i], "memtoRegM", tbl[i].mem[0], memtoRegM);
    if (tbl[i].mem[1])
      checkMask(names[i], tbl[i].mask, byteMaskM);   // Lanes matter for stores only
  endtask

  task automatic checkWriteback(input int i);
    checkBit(names[i], "regWriteW", tbl[i].wb[3], regWriteW);
    checkBit(names[i], "memtoRegW", tbl[i].wb[2], memtoRegW);
    checkBit(names[i], "pcSrcW", tbl[i].wb[1], pcSrcW);
    checkBit(names[i], "loadByteW", tbl[i].wb[0], loadByteW);
    if (tbl[i].wb[2])
      checkOffset(names[i], tbl[i].aluResult[1:0], byteOffsetW);  // Load lane from the address
  endtask

  task automatic waitResetRelease(output logic released);
    int cycles;
    cycles = 0;
    while (!rstN && cycles < 64) begin
      @(posedge clk);
      cycles++;
    end
    released = rstN;
  endtask

  // One row per cycle, checks first and then the next drive, all on the falling edge
  task automatic runTable();
    int n;
    n = tbl.size();
    for (int c = 0; c < n + 3; c++) begin
      @(negedge clk);
      if (c >= 1 && c - 1 < n)
        checkExecute(c - 1);
      if (c >= 2 && c - 2 < n)
        checkMemory(c - 2);
      if (c >= 3)
        checkWriteback(c - 3);
      if (c < n) begin
        instrD = tbl[c].instr;
        flushE = tbl[c].flush;
      end else begin
        instrD = '0;                   // Drain
        flushE = 1'b0;
      end
      if (c >= 1 && c - 1 < n) begin   // ALU results of the row now in execute
        aluFlagsE  = tbl[c - 1].aluFlags;
        aluResultE = tbl[c - 1].aluResult;
      end
    end
  endtask

  initial begin
    logic released;
    instrD     = '0;
    aluFlagsE  = '0;
    aluResultE = '0;
    stallE     = 1'b0;
    flushE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushW     = 1'b0;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    buildTable();
    @(negedge clk);
    checkResetValues();                // Still inside reset
    waitResetRelease(released);
    if (released)
      runTable();
    else begin
      timeouts++;
      $display("Reset was not released within 64 cycles");
    end
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/armIsaPkg.sv
logic/ctrlTypesPkg.sv
logic/stageIfs.sv
logic/condCheck.sv
logic/instrDecoder.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/armController.sv
test/tbArmController.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tbArmController -f vlog.f

out=$(./obj_dir/VtbArmController)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
